/* hw/mem_if_pkg.sv */
// ------------------------------
// AXI memory bridge definitions
// ------------------------------

package mem_if_pkg;

  // AxLEN width in bits
  localparam int LEN_WIDTH  = 8;

  // BRESP and RRESP width
  localparam int RESP_WIDTH = 2;

  localparam logic [RESP_WIDTH-1:0] RESP_OKAY = 2'b00;  // Only response returned

  // ------------------------------
  // Controller states
  // ------------------------------
  typedef enum logic [2:0]
  {
    IDLE,        // Arbitrate and issue first access
    SINGLE_RD,   // One-beat read on R
    BURST_RD,    // Multi-beat read on R
    WAIT_WDATA,  // AW taken, no W beat yet
    BURST_WR,    // Further W beats
    WR_RESP      // B response pending
  } fsm_state_t;

endpackage

/* hw/chan_fifo.sv */
// ------------------------------
// Valid/ready channel FIFO
// ------------------------------

`timescale 1ns/10ps

module chan_fifo
#(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
)
(
  input  logic             ACLK,
  input  logic             ARESETn,
  input  logic             in_valid_i,
  input  logic [WIDTH-1:0] in_data_i,
  output logic             in_ready_o,
  output logic             out_valid_o,
  output logic [WIDTH-1:0] out_data_o,
  input  logic             out_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;   // Items held
  logic             push;
  logic             pop;

  // Circular increment
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH-1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign in_ready_o  = (count_q != (PTR_W+1)'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;   // Both at once keeps the count
    end
  end

  // Storage
  always_ff @(posedge ACLK)
  begin
    if (push)
      mem_q[wr_ptr_q] <= in_data_i;
  end

endmodule

/* hw/burst_addr_gen.sv */
// ------------------------------
// Burst word address generator
// ------------------------------

`timescale 1ns/10ps

module burst_addr_gen
#(
  parameter int ADDR_WIDTH     = 32,
  parameter int DATA_WIDTH     = 64,
  parameter int ID_WIDTH       = 4,
  parameter int MEM_ADDR_WIDTH = 10
)
(
  input  logic                                ACLK,
  input  logic                                ARESETn,
  // Read side
  input  logic                                rd_capture_i,
  input  logic [ADDR_WIDTH-1:0]               rd_addr_i,
  input  logic [mem_if_pkg::LEN_WIDTH-1:0]    rd_len_i,
  input  logic [ID_WIDTH-1:0]                 rd_id_i,
  input  logic                                rd_advance_i,
  // Write side
  input  logic                                wr_capture_i,
  input  logic [ADDR_WIDTH-1:0]               wr_addr_i,
  input  logic [mem_if_pkg::LEN_WIDTH-1:0]    wr_len_i,
  input  logic [ID_WIDTH-1:0]                 wr_id_i,
  input  logic                                wr_advance_i,
  output logic [MEM_ADDR_WIDTH-1:0]           rd_word_o,
  output logic [mem_if_pkg::LEN_WIDTH-1:0]    rd_left_o,
  output logic [ID_WIDTH-1:0]                 rd_id_o,
  output logic [MEM_ADDR_WIDTH-1:0]           wr_word_o,
  output logic [mem_if_pkg::LEN_WIDTH-1:0]    wr_left_o,
  output logic [ID_WIDTH-1:0]                 wr_id_o
);

  localparam int OFFSET_BITS = $clog2(DATA_WIDTH/8);   // Byte offset bits in an address
  localparam int RD = 0;
  localparam int WR = 1;

  logic [1:0]                             cap;
  logic [1:0]                             adv;
  logic [MEM_ADDR_WIDTH-1:0]              cap_word [2];
  logic [mem_if_pkg::LEN_WIDTH-1:0]       cap_len  [2];
  logic [ID_WIDTH-1:0]                    cap_id   [2];
  logic [MEM_ADDR_WIDTH-1:0]              word_q   [2];
  logic [mem_if_pkg::LEN_WIDTH-1:0]       left_q   [2];
  logic [ID_WIDTH-1:0]                    id_q     [2];

  // ------------------------------
  // Read side at index 0 and write side at 1
  // ------------------------------
  assign cap         = {wr_capture_i, rd_capture_i};
  assign adv         = {wr_advance_i, rd_advance_i};
  assign cap_word[RD] = rd_addr_i[MEM_ADDR_WIDTH+OFFSET_BITS-1:OFFSET_BITS];
  assign cap_word[WR] = wr_addr_i[MEM_ADDR_WIDTH+OFFSET_BITS-1:OFFSET_BITS];
  assign cap_len[RD]  = rd_len_i;
  assign cap_len[WR]  = wr_len_i;
  assign cap_id[RD]   = rd_id_i;
  assign cap_id[WR]   = wr_id_i;

  // Remaining beats after the current one
  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      for (int s = 0; s < 2; s++)
        left_q[s] <= '0;
    end
    else
    begin
      for (int s = 0; s < 2; s++)
      begin
        if (cap[s])
          left_q[s] <= adv[s] ? cap_len[s] - 1'b1 : cap_len[s];  // First beat may go at once
        else if (adv[s])
          left_q[s] <= left_q[s] - 1'b1;
      end
    end
  end

  // Word index and ID
  always_ff @(posedge ACLK)
  begin
    for (int s = 0; s < 2; s++)
    begin
      if (cap[s])
      begin
        word_q[s] <= adv[s] ? cap_word[s] + 1'b1 : cap_word[s];
        id_q[s]   <= cap_id[s];
      end
      else if (adv[s])
        word_q[s] <= word_q[s] + 1'b1;
    end
  end

  assign rd_word_o = word_q[RD];
  assign rd_left_o = left_q[RD];
  assign rd_id_o   = id_q[RD];
  assign wr_word_o = word_q[WR];
  assign wr_left_o = left_q[WR];
  assign wr_id_o   = id_q[WR];

endmodule

/* hw/mem_if_fsm.sv */
// ------------------------------
// Bridge controller FSM
// ------------------------------

`timescale 1ns/10ps

module mem_if_fsm
#(
  parameter int MEM_ADDR_WIDTH = 10
)
(
  input  logic                              ACLK,
  input  logic                              ARESETn,
  input  logic                              ar_valid_i,
  input  logic [mem_if_pkg::LEN_WIDTH-1:0]  ar_len_i,
  input  logic [MEM_ADDR_WIDTH-1:0]         ar_word_i,
  input  logic                              aw_valid_i,
  input  logic [mem_if_pkg::LEN_WIDTH-1:0]  aw_len_i,
  input  logic [MEM_ADDR_WIDTH-1:0]         aw_word_i,
  input  logic                              w_valid_i,
  input  logic [MEM_ADDR_WIDTH-1:0]         rd_word_i,
  input  logic [mem_if_pkg::LEN_WIDTH-1:0]  rd_left_i,
  input  logic [MEM_ADDR_WIDTH-1:0]         wr_word_i,
  input  logic [mem_if_pkg::LEN_WIDTH-1:0]  wr_left_i,
  input  logic                              rready_i,
  input  logic                              bready_i,
  output logic                              ar_pop_o,
  output logic                              aw_pop_o,
  output logic                              w_pop_o,
  output logic                              rd_capture_o,
  output logic                              rd_advance_o,
  output logic                              wr_capture_o,
  output logic                              wr_advance_o,
  output logic                              rvalid_o,
  output logic                              rlast_o,
  output logic                              bvalid_o,
  output logic                              mem_cen_o,
  output logic                              mem_wen_o,
  output logic [MEM_ADDR_WIDTH-1:0]         mem_addr_o
);

  mem_if_pkg::fsm_state_t state_q;
  mem_if_pkg::fsm_state_t state_d;
  logic                   rr_flag_q;   // Low favours reads
  logic                   rvalid_q;
  logic                   rd_req;
  logic                   wr_req;
  logic                   take_rd;
  logic                   take_wr;

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      state_q   <= mem_if_pkg::IDLE;
      rr_flag_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end
    else
    begin
      state_q   <= state_d;
      rr_flag_q <= ~rr_flag_q;
      rvalid_q  <= rd_req;   // R data one cycle behind the SRAM read
    end
  end

  // Round-robin pick for IDLE only
  assign take_rd = ar_valid_i & (~rr_flag_q | ~aw_valid_i);
  assign take_wr = aw_valid_i & ~take_rd;

  // ------------------------------
  // Next state and strobes
  // ------------------------------
  always_comb
  begin
    state_d      = state_q;
    ar_pop_o     = 1'b0;
    aw_pop_o     = 1'b0;
    w_pop_o      = 1'b0;
    rd_capture_o = 1'b0;
    rd_advance_o = 1'b0;
    wr_capture_o = 1'b0;
    wr_advance_o = 1'b0;
    rd_req       = 1'b0;
    wr_req       = 1'b0;
    bvalid_o     = 1'b0;
    mem_addr_o   = rd_word_i;

    case (state_q)
      mem_if_pkg::IDLE:
      begin
        if (take_rd)
        begin
          ar_pop_o     = 1'b1;
          rd_capture_o = 1'b1;
          rd_req       = 1'b1;
          mem_addr_o   = ar_word_i;   // First read straight from the FIFO
          state_d      = (ar_len_i == '0) ? mem_if_pkg::SINGLE_RD : mem_if_pkg::BURST_RD;
        end
        else if (take_wr)
        begin
          aw_pop_o     = 1'b1;
          wr_capture_o = 1'b1;
          mem_addr_o   = aw_word_i;
          if (w_valid_i)
          begin
            w_pop_o      = 1'b1;
            wr_req       = 1'b1;
            wr_advance_o = 1'b1;
            state_d      = (aw_len_i == '0) ? mem_if_pkg::WR_RESP : mem_if_pkg::BURST_WR;
          end
          else
            state_d = mem_if_pkg::WAIT_WDATA;
        end
      end

      mem_if_pkg::SINGLE_RD, mem_if_pkg::BURST_RD:
      begin
        if (rready_i && rd_left_i == '0)
          state_d = mem_if_pkg::IDLE;   // Last beat taken
        else
        begin
          rd_req = 1'b1;   // Re-read same word while stalled
          if (rready_i)
          begin
            rd_advance_o = 1'b1;
            mem_addr_o   = rd_word_i + 1'b1;
          end
        end
      end

      mem_if_pkg::WAIT_WDATA, mem_if_pkg::BURST_WR:
      begin
        mem_addr_o = wr_word_i;
        if (w_valid_i)
        begin
          w_pop_o      = 1'b1;
          wr_req       = 1'b1;
          wr_advance_o = 1'b1;
          state_d      = (wr_left_i == '0) ? mem_if_pkg::WR_RESP : mem_if_pkg::BURST_WR;
        end
      end

      mem_if_pkg::WR_RESP:
      begin
        bvalid_o = 1'b1;
        if (bready_i)
          state_d = mem_if_pkg::IDLE;
      end

      default:
        state_d = mem_if_pkg::IDLE;
    endcase
  end

  assign rvalid_o  = rvalid_q;
  assign rlast_o   = rvalid_q & (rd_left_i == '0);
  assign mem_cen_o = ~(rd_req | wr_req);   // Active low strobes
  assign mem_wen_o = ~wr_req;

endmodule

/* hw/axi_mem_if.sv */
// ------------------------------
// AXI4 slave to SRAM bridge
// ------------------------------

`timescale 1ns/10ps

module axi_mem_if
#(
  parameter int ADDR_WIDTH     = 32,
  parameter int DATA_WIDTH     = 64,
  parameter int ID_WIDTH       = 4,
  parameter int MEM_ADDR_WIDTH = 10,
  parameter int FIFO_DEPTH     = 4
)
(
  input  logic                                 ACLK,
  input  logic                                 ARESETn,
  // AW
  input  logic [ID_WIDTH-1:0]                  awid_i,
  input  logic [ADDR_WIDTH-1:0]                awaddr_i,
  input  logic [mem_if_pkg::LEN_WIDTH-1:0]     awlen_i,
  input  logic                                 awvalid_i,
  output logic                                 awready_o,
  // W
  input  logic [DATA_WIDTH-1:0]                wdata_i,
  input  logic [DATA_WIDTH/8-1:0]              wstrb_i,
  input  logic                                 wlast_i,   // Burst end comes from AWLEN
  input  logic                                 wvalid_i,
  output logic                                 wready_o,
  // B
  output logic [ID_WIDTH-1:0]                  bid_o,
  output logic [mem_if_pkg::RESP_WIDTH-1:0]    bresp_o,
  output logic                                 bvalid_o,
  input  logic                                 bready_i,
  // AR
  input  logic [ID_WIDTH-1:0]                  arid_i,
  input  logic [ADDR_WIDTH-1:0]                araddr_i,
  input  logic [mem_if_pkg::LEN_WIDTH-1:0]     arlen_i,
  input  logic                                 arvalid_i,
  output logic                                 arready_o,
  // R
  output logic [ID_WIDTH-1:0]                  rid_o,
  output logic [DATA_WIDTH-1:0]                rdata_o,
  output logic [mem_if_pkg::RESP_WIDTH-1:0]    rresp_o,
  output logic                                 rlast_o,
  output logic                                 rvalid_o,
  input  logic                                 rready_i,
  // SRAM
  output logic                                 mem_cen_o,
  output logic                                 mem_wen_o,
  output logic [MEM_ADDR_WIDTH-1:0]            mem_addr_o,
  output logic [DATA_WIDTH-1:0]                mem_wdata_o,
  output logic [DATA_WIDTH/8-1:0]              mem_be_o,
  input  logic [DATA_WIDTH-1:0]                mem_rdata_i
);

  localparam int AX_WIDTH = ID_WIDTH + ADDR_WIDTH + mem_if_pkg::LEN_WIDTH;
  localparam int W_WIDTH  = DATA_WIDTH + DATA_WIDTH/8;
  localparam int WORD_LSB = $clog2(DATA_WIDTH/8);

  logic [AX_WIDTH-1:0]                aw_out;
  logic [AX_WIDTH-1:0]                ar_out;
  logic [W_WIDTH-1:0]                 w_out;
  logic                               aw_valid, aw_pop;
  logic                               ar_valid, ar_pop;
  logic                               w_valid, w_pop;
  logic [ID_WIDTH-1:0]                aw_id, ar_id;
  logic [ADDR_WIDTH-1:0]              aw_addr, ar_addr;
  logic [mem_if_pkg::LEN_WIDTH-1:0]   aw_len, ar_len;
  logic [MEM_ADDR_WIDTH-1:0]          aw_word, ar_word;
  logic [MEM_ADDR_WIDTH-1:0]          rd_word, wr_word;
  logic [mem_if_pkg::LEN_WIDTH-1:0]   rd_left, wr_left;
  logic                               rd_capture, rd_advance;
  logic                               wr_capture, wr_advance;

  // ------------------------------
  // Request FIFOs
  // ------------------------------
  chan_fifo #(.WIDTH(AX_WIDTH), .DEPTH(FIFO_DEPTH)) aw_fifo
  (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .in_valid_i  (awvalid_i),
    .in_data_i   ({awid_i, awaddr_i, awlen_i}),
    .in_ready_o  (awready_o),
    .out_valid_o (aw_valid),
    .out_data_o  (aw_out),
    .out_ready_i (aw_pop)
  );

  chan_fifo #(.WIDTH(W_WIDTH), .DEPTH(FIFO_DEPTH)) w_fifo
  (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .in_valid_i  (wvalid_i),
    .in_data_i   ({wdata_i, wstrb_i}),
    .in_ready_o  (wready_o),
    .out_valid_o (w_valid),
    .out_data_o  (w_out),
    .out_ready_i (w_pop)
  );

  chan_fifo #(.WIDTH(AX_WIDTH), .DEPTH(FIFO_DEPTH)) ar_fifo
  (
    .ACLK        (ACLK),
    .ARESETn     (ARESETn),
    .in_valid_i  (arvalid_i),
    .in_data_i   ({arid_i, araddr_i, arlen_i}),
    .in_ready_o  (arready_o),
    .out_valid_o (ar_valid),
    .out_data_o  (ar_out),
    .out_ready_i (ar_pop)
  );

  assign {aw_id, aw_addr, aw_len}  = aw_out;
  assign {ar_id, ar_addr, ar_len}  = ar_out;
  assign {mem_wdata_o, mem_be_o}   = w_out;
  assign aw_word = aw_addr[MEM_ADDR_WIDTH+WORD_LSB-1:WORD_LSB];   // First-beat word
  assign ar_word = ar_addr[MEM_ADDR_WIDTH+WORD_LSB-1:WORD_LSB];

  burst_addr_gen
  #(
    .ADDR_WIDTH     (ADDR_WIDTH),
    .DATA_WIDTH     (DATA_WIDTH),
    .ID_WIDTH       (ID_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  )
  addr_gen0
  (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .rd_capture_i (rd_capture),
    .rd_addr_i    (ar_addr),
    .rd_len_i     (ar_len),
    .rd_id_i      (ar_id),
    .rd_advance_i (rd_advance),
    .wr_capture_i (wr_capture),
    .wr_addr_i    (aw_addr),
    .wr_len_i     (aw_len),
    .wr_id_i      (aw_id),
    .wr_advance_i (wr_advance),
    .rd_word_o    (rd_word),
    .rd_left_o    (rd_left),
    .rd_id_o      (rid_o),
    .wr_word_o    (wr_word),
    .wr_left_o    (wr_left),
    .wr_id_o      (bid_o)
  );

  mem_if_fsm #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) fsm0
  (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .ar_valid_i   (ar_valid),
    .ar_len_i     (ar_len),
    .ar_word_i    (ar_word),
    .aw_valid_i   (aw_valid),
    .aw_len_i     (aw_len),
    .aw_word_i    (aw_word),
    .w_valid_i    (w_valid),
    .rd_word_i    (rd_word),
    .rd_left_i    (rd_left),
    .wr_word_i    (wr_word),
    .wr_left_i    (wr_left),
    .rready_i     (rready_i),
    .bready_i     (bready_i),
    .ar_pop_o     (ar_pop),
    .aw_pop_o     (aw_pop),
    .w_pop_o      (w_pop),
    .rd_capture_o (rd_capture),
    .rd_advance_o (rd_advance),
    .wr_capture_o (wr_capture),
    .wr_advance_o (wr_advance),
    .rvalid_o     (rvalid_o),
    .rlast_o      (rlast_o),
    .bvalid_o     (bvalid_o),
    .mem_cen_o    (mem_cen_o),
    .mem_wen_o    (mem_wen_o),
    .mem_addr_o   (mem_addr_o)
  );

  assign rdata_o = mem_rdata_i;   // SRAM output drives R directly
  assign rresp_o = mem_if_pkg::RESP_OKAY;
  assign bresp_o = mem_if_pkg::RESP_OKAY;

endmodule

/* tb/sram_model.sv */
// ------------------------------
// Single-port SRAM model
// ------------------------------

`timescale 1ns/10ps

module sram_model
#(
  parameter int ADDR_WIDTH = 10,
  parameter int DATA_WIDTH = 64
)
(
  input  logic                    ACLK,
  input  logic                    cen_i,     // Active low
  input  logic                    wen_i,     // Active low
  input  logic [ADDR_WIDTH-1:0]   addr_i,
  input  logic [DATA_WIDTH-1:0]   wdata_i,
  input  logic [DATA_WIDTH/8-1:0] be_i,
  output logic [DATA_WIDTH-1:0]   rdata_o
);

  logic [DATA_WIDTH-1:0] mem_q [2**ADDR_WIDTH];

  always_ff @(posedge ACLK)
  begin
    if (!cen_i)
    begin
      if (!wen_i)
      begin
        for (int b = 0; b < DATA_WIDTH/8; b++)
        begin
          if (be_i[b])
            mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];   // Enabled bytes only
        end
      end
      else
        rdata_o <= mem_q[addr_i];   // One-cycle read
    end
  end

endmodule

/* tb/axi_mem_if_assert.sv */
// ------------------------------
// Bridge protocol assertions
// ------------------------------

`timescale 1ns/10ps

module axi_mem_if_assert
#(
  parameter int DATA_WIDTH = 64,
  parameter int ID_WIDTH   = 4
)
(
  input logic                  ACLK,
  input logic                  ARESETn,
  input logic                  rvalid_i,
  input logic                  rready_i,
  input logic [DATA_WIDTH-1:0] rdata_i,
  input logic [ID_WIDTH-1:0]   rid_i,
  input logic                  rlast_i,
  input logic                  bvalid_i,
  input logic                  bready_i,
  input logic [ID_WIDTH-1:0]   bid_i,
  input logic                  mem_cen_i,
  input logic                  mem_wen_i
);

  int unsigned err_count = 0;   // Failed assertions so far

  // R beat held while stalled
  r_hold_a: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i) && $stable(rid_i) && $stable(rlast_i))
  else
  begin
    err_count++;
    $error("R beat changed while rready was low");
  end

  b_hold_a: assert property (@(posedge ACLK) disable iff (!ARESETn)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bid_i))
  else
  begin
    err_count++;
    $error("B response changed before bready");
  end

  // Write strobe only inside an enabled access
  wen_cen_a: assert property (@(posedge ACLK) disable iff (!ARESETn)
    !(mem_cen_i && !mem_wen_i))
  else
  begin
    err_count++;
    $error("SRAM write enable low while chip enable is high");
  end

  reset_a: assert property (@(posedge ACLK) $rose(ARESETn) |-> !rvalid_i && !bvalid_i)
  else
  begin
    err_count++;
    $error("Response valid high on the first cycle after reset");
  end

endmodule

bind axi_mem_if axi_mem_if_assert
#(
  .DATA_WIDTH (DATA_WIDTH),
  .ID_WIDTH   (ID_WIDTH)
)
assert0
(
  .ACLK      (ACLK),
  .ARESETn   (ARESETn),
  .rvalid_i  (rvalid_o),
  .rready_i  (rready_i),
  .rdata_i   (rdata_o),
  .rid_i     (rid_o),
  .rlast_i   (rlast_o),
  .bvalid_i  (bvalid_o),
  .bready_i  (bready_i),
  .bid_i     (bid_o),
  .mem_cen_i (mem_cen_o),
  .mem_wen_i (mem_wen_o)
);

/* tb/tb_axi_mem_if.sv */
// ------------------------------
// AXI memory bridge testbench
// ------------------------------

`timescale 1ns/10ps

module tb_axi_mem_if;

  localparam int ADDR_WIDTH     = 32;
  localparam int DATA_WIDTH     = 64;
  localparam int ID_WIDTH       = 4;
  localparam int MEM_ADDR_WIDTH = 10;
  localparam int FIFO_DEPTH     = 4;
  localparam int TIMEOUT        = 200;   // Cycles per wait

  logic                    ACLK;
  logic                    ARESETn;
  logic [ID_WIDTH-1:0]     awid;
  logic [ADDR_WIDTH-1:0]   awaddr;
  logic [7:0]              awlen;
  logic                    awvalid;
  logic                    awready;
  logic [DATA_WIDTH-1:0]   wdata;
  logic [DATA_WIDTH/8-1:0] wstrb;
  logic                    wlast;
  logic                    wvalid;
  logic                    wready;
  logic [ID_WIDTH-1:0]     bid;
  logic [1:0]              bresp;
  logic                    bvalid;
  logic                    bready;
  logic [ID_WIDTH-1:0]     arid;
  logic [ADDR_WIDTH-1:0]   araddr;
  logic [7:0]              arlen;
  logic                    arvalid;
  logic                    arready;
  logic [ID_WIDTH-1:0]     rid;
  logic [DATA_WIDTH-1:0]   rdata;
  logic [1:0]              rresp;
  logic                    rlast;
  logic                    rvalid;
  logic                    rready;
  logic                    mem_cen;
  logic                    mem_wen;
  logic [MEM_ADDR_WIDTH-1:0] mem_addr;
  logic [DATA_WIDTH-1:0]   mem_wdata;
  logic [DATA_WIDTH/8-1:0] mem_be;
  logic [DATA_WIDTH-1:0]   mem_rdata;

  int                      seed = 18555;
  int                      errors = 0;
  int                      checks = 0;
  int                      tests = 0;
  int                      errors_at_start;
  string                   test_name;
  logic [DATA_WIDTH-1:0]   shadow [2**MEM_ADDR_WIDTH];   // Expected SRAM words
  logic [DATA_WIDTH-1:0]   wq_data [$];
  logic [DATA_WIDTH/8-1:0] wq_strb [$];

  axi_mem_if
  #(
    .ADDR_WIDTH     (ADDR_WIDTH),
    .DATA_WIDTH     (DATA_WIDTH),
    .ID_WIDTH       (ID_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
    .FIFO_DEPTH     (FIFO_DEPTH)
  )
  dut0
  (
    .ACLK (ACLK), .ARESETn (ARESETn),
    .awid_i (awid), .awaddr_i (awaddr), .awlen_i (awlen),
    .awvalid_i (awvalid), .awready_o (awready),
    .wdata_i (wdata), .wstrb_i (wstrb), .wlast_i (wlast),
    .wvalid_i (wvalid), .wready_o (wready),
    .bid_o (bid), .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
    .arid_i (arid), .araddr_i (araddr), .arlen_i (arlen),
    .arvalid_i (arvalid), .arready_o (arready),
    .rid_o (rid), .rdata_o (rdata), .rresp_o (rresp), .rlast_o (rlast),
    .rvalid_o (rvalid), .rready_i (rready),
    .mem_cen_o (mem_cen), .mem_wen_o (mem_wen), .mem_addr_o (mem_addr),
    .mem_wdata_o (mem_wdata), .mem_be_o (mem_be), .mem_rdata_i (mem_rdata)
  );

  sram_model #(.ADDR_WIDTH(MEM_ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) mem0
  (
    .ACLK    (ACLK),
    .cen_i   (mem_cen),
    .wen_i   (mem_wen),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .be_i    (mem_be),
    .rdata_o (mem_rdata)
  );

  initial
  begin
    ACLK = 1'b0;
    forever #2 ACLK = ~ACLK;
  end

  // ------------------------------
  // Checks and bookkeeping
  // ------------------------------
  task automatic compare_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      errors++;
      $display("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("TIMEOUT in %s: %s did not arrive in time", test_name, what);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    tests++;
    $display("test %s done with %0d errors", test_name, errors - errors_at_start);
  endtask

  // Random upper bits and a zero byte offset
  function automatic logic [ADDR_WIDTH-1:0] byte_addr(input int word);
    logic [31:0] r;
    r = $random(seed);
    return {r[31:13], word[9:0], 3'b000};
  endfunction

  // Queue the W beats and merge strobed bytes into the shadow
  task automatic prep_write(input int word, input int len, input bit rand_strb);
    logic [DATA_WIDTH-1:0]   d;
    logic [DATA_WIDTH/8-1:0] s;
    wq_data.delete();
    wq_strb.delete();
    for (int i = 0; i <= len; i++)
    begin
      d = {$random(seed), $random(seed)};
      s = rand_strb ? 8'($random(seed)) : 8'hFF;
      wq_data.push_back(d);
      wq_strb.push_back(s);
      for (int b = 0; b < DATA_WIDTH/8; b++)
      begin
        if (s[b])
          shadow[word + i][b*8 +: 8] = d[b*8 +: 8];
      end
    end
  endtask

  // ------------------------------
  // Channel drivers
  // ------------------------------
  task automatic send_aw(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len);
    int n;
    awid    <= id;
    awaddr  <= addr;
    awlen   <= len;
    awvalid <= 1'b1;
    n = 0;
    do
    begin
      @(posedge ACLK);
      n++;
    end
    while (!awready && n < TIMEOUT);
    awvalid <= 1'b0;
    if (!awready)
      report_timeout("AW ready");
  endtask

  task automatic send_ar(input logic [3:0] id, input logic [31:0] addr, input logic [7:0] len);
    int n;
    arid    <= id;
    araddr  <= addr;
    arlen   <= len;
    arvalid <= 1'b1;
    n = 0;
    do
    begin
      @(posedge ACLK);
      n++;
    end
    while (!arready && n < TIMEOUT);
    arvalid <= 1'b0;
    if (!arready)
      report_timeout("AR ready");
  endtask

  task automatic send_w(input int len);
    int n;
    for (int i = 0; i <= len; i++)
    begin
      wdata  <= wq_data.pop_front();
      wstrb  <= wq_strb.pop_front();
      wlast  <= (i == len);
      wvalid <= 1'b1;
      n = 0;
      do
      begin
        @(posedge ACLK);
        n++;
      end
      while (!wready && n < TIMEOUT);
      if (!wready)
      begin
        report_timeout("W ready");
        break;
      end
    end
    wvalid <= 1'b0;
    wlast  <= 1'b0;
  endtask

  task automatic wait_b(input logic [3:0] id);
    int n;
    int hold;
    n = 0;
    hold = 1 + ($random(seed) & 3);   // Stall B a few cycles
    bready <= 1'b0;
    while (!bvalid && n < TIMEOUT)
    begin
      @(posedge ACLK);
      n++;
    end
    if (!bvalid)
    begin
      report_timeout("B valid");
      return;
    end
    repeat (hold) @(posedge ACLK);
    bready <= 1'b1;
    @(posedge ACLK);
    compare_value("bvalid", 1, bvalid);
    compare_value("bid", id, bid);
    compare_value("bresp", 0, bresp);
    bready <= 1'b0;
  endtask

  task automatic recv_r(input logic [3:0] id, input int word, input int len, input bit stall);
    int          beat;
    int          n;
    logic [31:0] r;
    beat = 0;
    n = 0;
    r = $random(seed);
    rready <= stall ? r[0] : 1'b1;
    while (beat <= len && n < TIMEOUT * (len + 1))
    begin
      @(posedge ACLK);
      n++;
      if (rvalid && rready)
      begin
        compare_value("rdata", shadow[word + beat], rdata);
        compare_value("rid", id, rid);
        compare_value("rlast", beat == len, rlast);
        compare_value("rresp", 0, rresp);
        beat++;
      end
      r = $random(seed);
      rready <= (stall && beat <= len) ? r[0] : (beat <= len);
    end
    if (beat <= len)
      report_timeout("R beat");
    else
    begin
      @(posedge ACLK);
      compare_value("rvalid after last beat", 0, rvalid);   // No extra beat
    end
  endtask

  task automatic write_txn(input logic [3:0] id, input int word, input int len, input int gap);
    fork
      send_aw(id, byte_addr(word), len[7:0]);
      begin
        repeat (gap) @(posedge ACLK);
        send_w(len);
      end
    join
    wait_b(id);
  endtask

  task automatic read_txn(input logic [3:0] id, input int word, input int len, input bit stall);
    send_ar(id, byte_addr(word), len[7:0]);
    recv_r(id, word, len, stall);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial
  begin
    ARESETn <= 1'b0;
    awid <= '0;
    awaddr <= '0;
    awlen <= '0;
    awvalid <= 1'b0;
    wdata <= '0;
    wstrb <= '0;
    wlast <= 1'b0;
    wvalid <= 1'b0;
    bready <= 1'b0;
    arid <= '0;
    araddr <= '0;
    arlen <= '0;
    arvalid <= 1'b0;
    rready <= 1'b0;
    repeat (8) @(posedge ACLK);
    ARESETn <= 1'b1;
    repeat (2) @(posedge ACLK);

    start_test("single_write_read");
    prep_write(10, 0, 1'b0);
    write_txn(4'h3, 10, 0, 0);
    read_txn(4'h5, 10, 0, 1'b0);
    finish_test();

    start_test("burst_strobes");
    prep_write(100, 15, 1'b0);   // Full words first
    write_txn(4'h1, 100, 15, 0);
    prep_write(100, 15, 1'b1);
    write_txn(4'h2, 100, 15, 0);
    read_txn(4'h4, 100, 15, 1'b0);
    finish_test();

    start_test("aw_before_w");
    prep_write(300, 3, 1'b0);
    write_txn(4'h7, 300, 3, 6);
    read_txn(4'h8, 300, 3, 1'b0);
    finish_test();

    start_test("read_backpressure");
    read_txn(4'h9, 100, 15, 1'b1);
    finish_test();

    start_test("concurrent_rd_wr");
    prep_write(500, 2, 1'b0);
    fork
      write_txn(4'hA, 500, 2, 0);
      read_txn(4'hB, 100, 3, 1'b0);
    join
    read_txn(4'hC, 500, 2, 1'b0);
    finish_test();

    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, checks, errors, dut0.assert0.err_count);
    if (errors == 0 && dut0.assert0.err_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* filelist.f */
hw/mem_if_pkg.sv
hw/chan_fifo.sv
hw/burst_addr_gen.sv
hw/mem_if_fsm.sv
hw/axi_mem_if.sv
tb/sram_model.sv
tb/axi_mem_if_assert.sv
tb/tb_axi_mem_if.sv
